//--- decode_core.f
+incdir+include
design/decode_pkg.sv
design/decode_1st.sv
design/decode_2nd.sv
design/operand_read.sv
design/decode_core.sv
verif/decode_core_checker.sv
verif/decode_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the decode front with Verilator and runs the directed tests
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module decode_core_tb -f decode_core.f -o decode_core_sim \
    && ./obj_dir/decode_core_sim | tee /dev/stderr | grep -x "Simulation passed" > /dev/null \
    && exit 0 \
    || exit 1

//--- verif/decode_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_core_tb;

    import decode_pkg::*;

    localparam int MAX_CYCLES = 2000;

    logic CLK;
    logic rst;
    logic flush;
    logic stall;
    logic inst_valid;
    logic [`DEC_XLEN-1:0] inst_pc;
    logic [`DEC_XLEN-1:0] inst_data;
    wb_t wb;
    issue_t issue;

    logic [`DEC_XLEN-1:0] shadow [`DEC_NUM_REGS];
    issue_t expq [$];
    int dueq [$];
    issue_t exp_pkt;
    issue_t held;
    logic fresh = 1'b0;
    // latency is counted in non-stalled edges only
    int moves = 0;
    int due;
    int errors = 0;
    int cycles = 0;
    int seed = 32'hf2fd;
    int mark;
    logic [6:0] opcodes [9] = '{7'b0110111, 7'b0010111, 7'b1101111, 7'b1100111, 7'b1100011,
                                7'b0000011, 7'b0100011, 7'b0010011, 7'b0110011};

    decode_core decode_core_inst (
        .CLK        (CLK),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_data  (inst_data),
        .wb         (wb),
        .issue      (issue)
    );

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        fresh = !stall;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles with %0d packets outstanding", cycles, expq.size());
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic alu_op_e arith_op(input logic [2:0] f3);
        alu_op_e ops [8] = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU,
                             ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
        return ops[f3];
    endfunction

    // expected issue packet from the RV32I decode rules and the shadow registers
    function automatic issue_t expect_issue(input logic [31:0] w, input logic [31:0] pc);
        issue_t p;
        logic [2:0] f3;
        logic [6:0] f7;
        logic u1;
        logic u2;
        f3 = w[14:12];
        f7 = w[31:25];
        p = '0;
        p.valid = 1'b1;
        p.pc = pc;
        p.rd = w[11:7];
        p.alu_op = ALU_ADD;
        case (w[6:0])
            7'b0110111: p.op_class = OP_LUI;
            7'b0010111: p.op_class = OP_AUIPC;
            7'b1101111: p.op_class = OP_JAL;
            7'b1100111: p.op_class = OP_JALR;
            7'b1100011: p.op_class = OP_BRANCH;
            7'b0000011: p.op_class = OP_LOAD;
            7'b0100011: p.op_class = OP_STORE;
            7'b0010011: p.op_class = OP_IMM;
            7'b0110011: p.op_class = OP_REG;
            7'b0001111: p.op_class = OP_FENCE;
            7'b1110011: p.op_class = OP_SYSTEM;
            default:    p.op_class = OP_ILLEGAL;
        endcase
        p.illegal = (p.op_class == OP_ILLEGAL);
        case (p.op_class)
            OP_IMM, OP_LOAD, OP_JALR: p.imm = {{20{w[31]}}, w[31:20]};
            OP_STORE:  p.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            OP_BRANCH: p.imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OP_LUI, OP_AUIPC: p.imm = {w[31:12], 12'b0};
            OP_JAL:    p.imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            default:   p.imm = '0;
        endcase
        if (p.op_class == OP_REG) begin
            p.alu_op = arith_op(f3);
            if (f7 == 7'h20 && f3 == 3'b000) p.alu_op = ALU_SUB;
            else if (f7 == 7'h20 && f3 == 3'b101) p.alu_op = ALU_SRA;
            else if (f7 != 7'h00) p.illegal = 1'b1;
        end else if (p.op_class == OP_IMM) begin
            p.alu_op = (f3 == 3'b101 && f7 == 7'h20) ? ALU_SRA : arith_op(f3);
        end else if (p.op_class == OP_LUI) begin
            p.alu_op = ALU_PASS_B;
        end else if (p.op_class == OP_BRANCH) begin
            if (f3 == 3'b010 || f3 == 3'b011) p.illegal = 1'b1;
            else if (f3[2:1] == 2'b00) p.alu_op = ALU_SUB;
            else if (f3[2:1] == 2'b10) p.alu_op = ALU_SLT;
            else p.alu_op = ALU_SLTU;
        end
        u1 = p.op_class inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE, OP_IMM, OP_REG};
        u2 = p.op_class inside {OP_BRANCH, OP_STORE, OP_REG};
        p.writes_rd = !p.illegal && (p.op_class inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                                         OP_LOAD, OP_IMM, OP_REG});
        p.rs1_data = (u1 && w[19:15] != 0) ? shadow[w[19:15]] : '0;
        p.rs2_data = (u2 && w[24:20] != 0) ? shadow[w[24:20]] : '0;
        return p;
    endfunction

    task automatic check_field(input string name, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp) else begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, exp, got);
            errors++;
        end
    endtask

    // every fresh valid packet on issue must match the oldest expectation in its own slot
    always @(negedge CLK) begin
        if (fresh) begin
            moves++;
        end
        if (!rst && fresh && issue.valid) begin
            assert (expq.size() != 0) else begin
                $display("unexpected issue packet at %0t with pc %h", $time, issue.pc);
                errors++;
            end
            if (expq.size() != 0) begin
                exp_pkt = expq.pop_front();
                due = dueq.pop_front();
                assert (moves == due) else begin
                    $display("packet with pc %h came out %0d cycles off its latency at %0t",
                             issue.pc, moves - due, $time);
                    errors++;
                end
                check_field("issue.pc", exp_pkt.pc, issue.pc);
                check_field("issue.op_class", 32'(exp_pkt.op_class), 32'(issue.op_class));
                check_field("issue.alu_op", 32'(exp_pkt.alu_op), 32'(issue.alu_op));
                check_field("issue.imm", exp_pkt.imm, issue.imm);
                check_field("issue.rd", 32'(exp_pkt.rd), 32'(issue.rd));
                check_field("issue.writes_rd", 32'(exp_pkt.writes_rd), 32'(issue.writes_rd));
                check_field("issue.illegal", 32'(exp_pkt.illegal), 32'(issue.illegal));
                check_field("issue.rs1_data", exp_pkt.rs1_data, issue.rs1_data);
                check_field("issue.rs2_data", exp_pkt.rs2_data, issue.rs2_data);
            end
        end
    end

    task automatic send(input logic [31:0] w, input logic [31:0] pc, input logic keep);
        @(posedge CLK);
        inst_valid <= 1'b1;
        inst_data <= w;
        inst_pc <= pc;
        if (keep) begin
            expq.push_back(expect_issue(w, pc));
            // the driving edge plus one edge per stage
            dueq.push_back(moves + 4);
        end
    endtask

    task automatic idle();
        @(posedge CLK);
        inst_valid <= 1'b0;
        wb.en <= 1'b0;
    endtask

    task automatic write_reg(input logic [4:0] a, input logic [31:0] d);
        @(posedge CLK);
        wb <= {1'b1, a, d};
        if (a != 0) shadow[a] = d;
        idle();
    endtask

    task automatic drain();
        idle();
        while (expq.size() != 0) @(posedge CLK);
        repeat (4) idle();
    endtask

    task automatic report(input string name);
        $display("%s: %0d errors", name, errors - mark);
        mark = errors;
    endtask

    function automatic logic [31:0] legalize(input logic [31:0] w);
        if (w[6:0] == 7'b0110011) begin
            w[31:25] = (w[30] && (w[14:12] == 3'b000 || w[14:12] == 3'b101)) ? 7'h20 : 7'h00;
        end
        if (w[6:0] == 7'b1100011 && w[14:13] == 2'b01) w[14] = 1'b1;
        return w;
    endfunction

    function automatic logic [31:0] reg_op(input logic [4:0] rd, rs1, rs2);
        return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
    endfunction

    task automatic test_reset_idle();
        repeat (10) begin
            idle();
            #1 check_field("issue.valid", 0, 32'(issue.valid));
        end
        report("reset_idle");
    endtask

    task automatic test_formats();
        logic [31:0] w;
        for (int s = 0; s < 2; s++) begin
            for (int i = 0; i < 9; i++) begin
                w = $random(seed);
                w[6:0] = opcodes[i];
                w[31] = s[0];
                send(legalize(w), 32'h1000 + 4 * (i + 9 * s), 1'b1);
            end
        end
        drain();
        report("formats");
    endtask

    task automatic test_registers();
        for (int r = 0; r < 6; r++) write_reg(r[4:0], $random(seed));
        send(reg_op(5'd6, 5'd1, 5'd2), 32'h2000, 1'b1);
        send({7'h12, 5'd4, 5'd3, 3'b010, 5'h1c, 7'b0100011}, 32'h2004, 1'b1);
        // x0 was written above and must still read zero
        send(reg_op(5'd7, 5'd0, 5'd5), 32'h2008, 1'b1);
        drain();
        // write lands in the cycle operand_read samples the instruction
        shadow[9] = 32'hcafe_0009;
        send(reg_op(5'd8, 5'd9, 5'd1), 32'h200c, 1'b1);
        idle();
        @(posedge CLK);
        wb <= {1'b1, 5'd9, 32'hcafe_0009};
        idle();
        drain();
        report("registers");
    endtask

    task automatic test_stall_flush();
        for (int i = 0; i < 3; i++) send(legalize($random(seed)) | 32'h13, 32'h3000 + 4 * i, 1'b1);
        @(posedge CLK);
        inst_valid <= 1'b0;
        stall <= 1'b1;
        @(negedge CLK);
        held = issue;
        repeat (4) begin
            @(negedge CLK);
            check_field("issue.pc", held.pc, issue.pc);
            check_field("issue.imm", held.imm, issue.imm);
        end
        @(posedge CLK);
        stall <= 1'b0;
        drain();
        send(reg_op(5'd1, 5'd2, 5'd3), 32'h3100, 1'b0);
        send(reg_op(5'd4, 5'd5, 5'd6), 32'h3104, 1'b0);
        send(reg_op(5'd7, 5'd8, 5'd9), 32'h3108, 1'b0);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        inst_valid <= 1'b0;
        send(reg_op(5'd10, 5'd1, 5'd2), 32'h3200, 1'b1);
        drain();
        report("stall_flush");
    endtask

    task automatic test_illegal();
        send(32'h0000_007f, 32'h4000, 1'b1);
        send({7'h01, 5'd2, 5'd1, 3'b000, 5'd3, 7'b0110011}, 32'h4004, 1'b1);
        send({7'h00, 5'd2, 5'd1, 3'b010, 5'd0, 7'b1100011}, 32'h4008, 1'b1);
        drain();
        report("illegal");
    endtask

    task automatic test_stream();
        logic [31:0] w;
        for (int i = 0; i < 60; i++) begin
            w = $random(seed);
            w[6:0] = opcodes[$unsigned($random(seed)) % 9];
            send(legalize(w), 32'h5000 + 4 * i, 1'b1);
        end
        drain();
        report("stream");
    endtask

    initial begin
        rst = 1'b1;
        flush = 1'b0;
        stall = 1'b0;
        inst_valid = 1'b0;
        inst_pc = '0;
        inst_data = '0;
        wb = '0;
        mark = 0;
        for (int r = 0; r < `DEC_NUM_REGS; r++) shadow[r] = '0;
        repeat (3) @(posedge CLK);
        rst <= 1'b0;
        test_reset_idle();
        test_formats();
        test_registers();
        test_stall_flush();
        test_illegal();
        test_stream();
        $display("checks done after %0d cycles, %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verif/decode_core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module decode_core_checker (
    input wire                 CLK,
    input wire                 rst,
    input wire                 flush,
    input wire                 stall,
    input wire decode_pkg::issue_t issue
);

    import decode_pkg::*;

    // a clearing strobe empties the issue register at the next edge
    clear_empties_issue: assert property (@(posedge CLK)
        (rst || flush) |=> !issue.valid)
    else $error("issue valid one cycle after rst or flush");

    // a stall freezes the whole packet
    stall_holds_issue: assert property (@(posedge CLK) disable iff (rst)
        (stall && !flush) |=> $stable(issue))
    else $error("issue changed across a stall cycle");

    illegal_never_writes: assert property (@(posedge CLK) disable iff (rst)
        (issue.valid && issue.illegal) |-> !issue.writes_rd)
    else $error("illegal instruction issued with writes_rd set");

endmodule

bind decode_core decode_core_checker decode_core_checker_inst (
    .CLK   (CLK),
    .rst   (rst),
    .flush (flush),
    .stall (stall),
    .issue (issue)
);

`default_nettype wire

//--- design/decode_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_core (
    input  wire                   CLK,
    input  wire                   rst,
    input  wire                   flush,
    input  wire                   stall,
    input  wire                   inst_valid,
    input  wire [`DEC_XLEN-1:0]   inst_pc,
    input  wire [`DEC_XLEN-1:0]   inst_data,
    input  wire decode_pkg::wb_t  wb,
    output decode_pkg::issue_t    issue
);

    import decode_pkg::*;

    decode1_t  d1;
    decode2_t  d2;

    decode_1st decode_1st_inst (
        .CLK        (CLK),
        .rst        (rst),
        .flush      (flush),
        .stall      (stall),
        .inst_valid (inst_valid),
        .inst_pc    (inst_pc),
        .inst_data  (inst_data),
        .d1         (d1)
    );

    decode_2nd decode_2nd_inst (
        .CLK   (CLK),
        .rst   (rst),
        .flush (flush),
        .stall (stall),
        .d1    (d1),
        .d2    (d2)
    );

    // register file and issue register live in the last stage
    operand_read operand_read_inst (
        .CLK   (CLK),
        .rst   (rst),
        .flush (flush),
        .stall (stall),
        .d2    (d2),
        .wb    (wb),
        .issue (issue)
    );

endmodule

`default_nettype wire

//--- design/operand_read.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module operand_read (
    input  wire                   CLK,
    input  wire                   rst,
    input  wire                   flush,
    input  wire                   stall,
    input  wire decode_pkg::decode2_t d2,
    input  wire decode_pkg::wb_t  wb,
    output decode_pkg::issue_t    issue
);

    import decode_pkg::*;

    logic [`DEC_XLEN-1:0]  regs [`DEC_NUM_REGS];
    logic [`DEC_XLEN-1:0]  rs1_data;
    logic [`DEC_XLEN-1:0]  rs2_data;
    issue_t                issue_next;

    // writeback keeps going while the pipe is stalled
    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 0; i < `DEC_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.en && wb.addr != '0) begin
            regs[wb.addr] <= wb.data;
        end
    end

    // a write landing in the same cycle is bypassed so issue sees the new value
    function automatic logic [`DEC_XLEN-1:0] read_src(
        input logic [`DEC_REG_ADDR_W-1:0] addr,
        input logic                       used
    );
        logic [`DEC_XLEN-1:0] val;
        if (!used || addr == '0) begin
            val = '0;
        end else if (wb.en && wb.addr == addr) begin
            val = wb.data;
        end else begin
            val = regs[addr];
        end
        return val;
    endfunction

    always_comb begin
        rs1_data = read_src(d2.rs1, d2.use_rs1);
        rs2_data = read_src(d2.rs2, d2.use_rs2);
    end

    always_comb begin
        issue_next.valid     = d2.valid;
        issue_next.pc        = d2.pc;
        issue_next.op_class  = d2.op_class;
        issue_next.alu_op    = d2.alu_op;
        issue_next.rd        = d2.rd;
        issue_next.writes_rd = d2.writes_rd;
        issue_next.illegal   = d2.illegal;
        issue_next.rs1_data  = rs1_data;
        issue_next.rs2_data  = rs2_data;
        issue_next.imm       = d2.imm;
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            issue <= issue_next;
        end
        if (rst || flush) begin
            issue.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/decode_2nd.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_2nd (
    input  wire                   CLK,
    input  wire                   rst,
    input  wire                   flush,
    input  wire                   stall,
    input  wire decode_pkg::decode1_t d1,
    output decode_pkg::decode2_t  d2
);

    import decode_pkg::*;

    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_IMM    = 7'b0010011;
    localparam logic [6:0] OPC_REG    = 7'b0110011;
    localparam logic [6:0] OPC_FENCE  = 7'b0001111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    op_class_e             op_class;
    alu_op_e               alu_op;
    logic                  bad_funct;
    logic                  illegal;
    logic [`DEC_XLEN-1:0]  imm;
    decode2_t              d2_next;

    // shared funct3 table for register and immediate arithmetic
    function automatic alu_op_e alu_from_funct3(input logic [2:0] funct3);
        alu_op_e op;
        case (funct3)
            3'b000:  op = ALU_ADD;
            3'b001:  op = ALU_SLL;
            3'b010:  op = ALU_SLT;
            3'b011:  op = ALU_SLTU;
            3'b100:  op = ALU_XOR;
            3'b101:  op = ALU_SRL;
            3'b110:  op = ALU_OR;
            default: op = ALU_AND;
        endcase
        return op;
    endfunction

    always_comb begin
        case (d1.opcode)
            OPC_LUI:    op_class = OP_LUI;
            OPC_AUIPC:  op_class = OP_AUIPC;
            OPC_JAL:    op_class = OP_JAL;
            OPC_JALR:   op_class = OP_JALR;
            OPC_BRANCH: op_class = OP_BRANCH;
            OPC_LOAD:   op_class = OP_LOAD;
            OPC_STORE:  op_class = OP_STORE;
            OPC_IMM:    op_class = OP_IMM;
            OPC_REG:    op_class = OP_REG;
            OPC_FENCE:  op_class = OP_FENCE;
            OPC_SYSTEM: op_class = OP_SYSTEM;
            default:    op_class = OP_ILLEGAL;
        endcase
    end

    // each format extends from its own top bit
    always_comb begin
        case (op_class)
            OP_IMM, OP_LOAD, OP_JALR: imm = {{(`DEC_XLEN-12){d1.imm_i[11]}}, d1.imm_i[11:0]};
            OP_STORE:                 imm = {{(`DEC_XLEN-12){d1.imm_s[11]}}, d1.imm_s[11:0]};
            OP_BRANCH:                imm = {{(`DEC_XLEN-13){d1.imm_b[12]}}, d1.imm_b[12:0]};
            OP_LUI, OP_AUIPC:         imm = d1.imm_u;
            OP_JAL:                   imm = {{(`DEC_XLEN-21){d1.imm_j[20]}}, d1.imm_j[20:0]};
            default:                  imm = '0;
        endcase
    end

    always_comb begin
        alu_op    = ALU_ADD;
        bad_funct = 1'b0;
        case (op_class)
            OP_REG: begin
                alu_op = alu_from_funct3(d1.funct3);
                if (d1.funct7 == 7'h20) begin
                    if (d1.funct3 == 3'b000) begin
                        alu_op = ALU_SUB;
                    end else if (d1.funct3 == 3'b101) begin
                        alu_op = ALU_SRA;
                    end else begin
                        bad_funct = 1'b1;
                    end
                end else if (d1.funct7 != 7'h00) begin
                    bad_funct = 1'b1;
                end
            end
            OP_IMM: begin
                alu_op = alu_from_funct3(d1.funct3);
                if (d1.funct3 == 3'b101 && d1.funct7 == 7'h20) begin
                    alu_op = ALU_SRA;
                end
            end
            OP_LUI: alu_op = ALU_PASS_B;
            // compare type comes from funct3[2:1], 01 has no branch defined
            OP_BRANCH: begin
                case (d1.funct3[2:1])
                    2'b00:   alu_op = ALU_SUB;
                    2'b10:   alu_op = ALU_SLT;
                    2'b11:   alu_op = ALU_SLTU;
                    default: bad_funct = 1'b1;
                endcase
            end
            default: alu_op = ALU_ADD;
        endcase
    end

    assign illegal = (op_class == OP_ILLEGAL) || bad_funct;

    always_comb begin
        d2_next.valid     = d1.valid;
        d2_next.pc        = d1.pc;
        d2_next.op_class  = op_class;
        d2_next.alu_op    = alu_op;
        d2_next.rd        = d1.rd;
        d2_next.rs1       = d1.rs1;
        d2_next.rs2       = d1.rs2;
        d2_next.use_rs1   = op_class inside {OP_JALR, OP_BRANCH, OP_LOAD, OP_STORE,
                                             OP_IMM, OP_REG};
        d2_next.use_rs2   = op_class inside {OP_BRANCH, OP_STORE, OP_REG};
        d2_next.writes_rd = !illegal && (op_class inside {OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
                                                           OP_LOAD, OP_IMM, OP_REG});
        d2_next.illegal   = illegal;
        d2_next.imm       = imm;
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            d2 <= d2_next;
        end
        if (rst || flush) begin
            d2.valid <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- design/decode_1st.sv
`timescale 1ns/1ps
`default_nettype none

`include "decode_defines.svh"

module decode_1st (
    input  wire                   CLK,
    input  wire                   rst,
    input  wire                   flush,
    input  wire                   stall,
    input  wire                   inst_valid,
    input  wire [`DEC_XLEN-1:0]   inst_pc,
    input  wire [`DEC_XLEN-1:0]   inst_data,
    output decode_pkg::decode1_t  d1
);

    logic                  valid_q;
    logic [`DEC_XLEN-1:0]  pc_q;
    logic [`DEC_XLEN-1:0]  inst_q;

    // flush wins over stall so a frozen pipe can still be emptied
    always_ff @(posedge CLK) begin
        if (rst || flush) begin
            valid_q <= 1'b0;
        end else if (!stall) begin
            valid_q <= inst_valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (!stall) begin
            pc_q   <= inst_pc;
            inst_q <= inst_data;
        end
    end

    // field split is pure wiring off the registered word
    always_comb begin
        d1.valid  = valid_q;
        d1.pc     = pc_q;
        d1.opcode = inst_q[6:0];
        d1.rd     = inst_q[11:7];
        d1.funct3 = inst_q[14:12];
        d1.rs1    = inst_q[19:15];
        d1.rs2    = inst_q[24:20];
        d1.funct7 = inst_q[31:25];
        // immediates stay zero-extended here, sign handling is left to the next stage
        d1.imm_i  = {20'b0, inst_q[31:20]};
        d1.imm_s  = {20'b0, inst_q[31:25], inst_q[11:7]};
        d1.imm_b  = {19'b0, inst_q[31], inst_q[7], inst_q[30:25], inst_q[11:8], 1'b0};
        d1.imm_u  = {inst_q[31:12], 12'b0};
        d1.imm_j  = {11'b0, inst_q[31], inst_q[19:12], inst_q[20], inst_q[30:21], 1'b0};
    end

endmodule

`default_nettype wire

//--- design/decode_pkg.sv
`default_nettype none

`include "decode_defines.svh"

package decode_pkg;

    // instruction class as seen by execute
    typedef enum logic [3:0] {
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        OP_BRANCH,
        OP_LOAD,
        OP_STORE,
        OP_IMM,
        OP_REG,
        OP_FENCE,
        OP_SYSTEM,
        OP_ILLEGAL
    } op_class_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B
    } alu_op_e;

    // raw fields straight out of the instruction word, immediates not yet extended
    typedef struct packed {
        logic                        valid;
        logic [`DEC_XLEN-1:0]        pc;
        logic [6:0]                  opcode;
        logic [`DEC_REG_ADDR_W-1:0]  rd;
        logic [`DEC_REG_ADDR_W-1:0]  rs1;
        logic [`DEC_REG_ADDR_W-1:0]  rs2;
        logic [2:0]                  funct3;
        logic [6:0]                  funct7;
        logic [`DEC_XLEN-1:0]        imm_i;
        logic [`DEC_XLEN-1:0]        imm_s;
        logic [`DEC_XLEN-1:0]        imm_b;
        logic [`DEC_XLEN-1:0]        imm_u;
        logic [`DEC_XLEN-1:0]        imm_j;
    } decode1_t;

    typedef struct packed {
        logic                        valid;
        logic [`DEC_XLEN-1:0]        pc;
        op_class_e                   op_class;
        alu_op_e                     alu_op;
        logic [`DEC_REG_ADDR_W-1:0]  rd;
        logic [`DEC_REG_ADDR_W-1:0]  rs1;
        logic [`DEC_REG_ADDR_W-1:0]  rs2;
        logic                        use_rs1;
        logic                        use_rs2;
        logic                        writes_rd;
        logic                        illegal;
        logic [`DEC_XLEN-1:0]        imm;
    } decode2_t;

    typedef struct packed {
        logic                        valid;
        logic [`DEC_XLEN-1:0]        pc;
        op_class_e                   op_class;
        alu_op_e                     alu_op;
        logic [`DEC_REG_ADDR_W-1:0]  rd;
        logic                        writes_rd;
        logic                        illegal;
        logic [`DEC_XLEN-1:0]        rs1_data;
        logic [`DEC_XLEN-1:0]        rs2_data;
        logic [`DEC_XLEN-1:0]        imm;
    } issue_t;

    typedef struct packed {
        logic                        en;
        logic [`DEC_REG_ADDR_W-1:0]  addr;
        logic [`DEC_XLEN-1:0]        data;
    } wb_t;

endpackage

`default_nettype wire

//--- include/decode_defines.svh
`ifndef DECODE_DEFINES_SVH
`define DECODE_DEFINES_SVH

// widths of the RV32I decode front

// data path and program counter width
`define DEC_XLEN 32

// integer register file size
`define DEC_NUM_REGS 32

// register specifier width, enough to index every register
`define DEC_REG_ADDR_W 5

`endif
